//--- hw/alu.sv
`timescale 1ns/10ps

module alu import core_cfg_pkg::*, rv_isa_pkg::*; (
    input  alu_op_t         alu_op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result,
    output logic            less,
    output logic            zero
);

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic [4:0]      shamt;

    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = b[4:0];

    // unsigned only for sltu, signed for slt and everything else
    assign less = (alu_op == alu_sltu) ? (a < b) : ($signed(a) < $signed(b));
    // equality from the difference
    assign zero = (diff == '0);

    always_comb begin
        case (alu_op[2:0])
            // bit 3 turns add into sub
            3'b000:  result = alu_op[3] ? diff : sum;
            3'b001:  result = a << shamt;
            3'b010:  result = {{(xlen-1){1'b0}}, less};
            3'b011:  result = {{(xlen-1){1'b0}}, less};
            3'b100:  result = a ^ b;
            // bit 3 selects arithmetic shift
            3'b101:  result = alu_op[3] ? $unsigned($signed(a) >>> shamt) : a >> shamt;
            3'b110:  result = a | b;
            default: result = a & b;
        endcase
    end

endmodule

//--- hw/control_unit.sv
`timescale 1ns/10ps

module control_unit import core_cfg_pkg::*, rv_isa_pkg::*; (
    input  logic [xlen-1:0] instr,
    input  logic            less,
    input  logic            zero,
    output imm_kind_t       imm_kind,
    output alu_op_t         alu_op,
    output alu_a_src_t      alu_a_src,
    output alu_b_src_t      alu_b_src,
    output pc_base_t        pc_base,
    output logic            reg_we,
    output logic            take_target
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7_bit;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign f7_bit = instr[30];

    always_comb begin
        // unknown opcodes fall through as a no-op
        imm_kind    = imm_i;
        alu_op      = alu_add;
        alu_a_src   = a_reg;
        alu_b_src   = b_reg;
        pc_base     = base_pc;
        reg_we      = 1'b0;
        take_target = 1'b0;
        case (opcode)
            op_reg: begin
                // bit 30 only means something for add/sub and srl/sra
                alu_op = alu_op_t'({f7_bit && (funct3 == f3_add || funct3 == f3_sr), funct3});
                reg_we = 1'b1;
            end
            op_imm: begin
                // addi has no subtract form, srai keeps bit 30
                alu_op    = alu_op_t'({f7_bit && (funct3 == f3_sr), funct3});
                alu_b_src = b_imm;
                reg_we    = 1'b1;
            end
            op_lui: begin
                // rs1 forced to x0 in the top, so add passes imm
                imm_kind  = imm_u;
                alu_b_src = b_imm;
                reg_we    = 1'b1;
            end
            op_auipc: begin
                imm_kind  = imm_u;
                alu_a_src = a_pc;
                alu_b_src = b_imm;
                reg_we    = 1'b1;
            end
            op_jal, op_jalr: begin
                // link value pc + 4 through the alu
                imm_kind    = (opcode == op_jal) ? imm_j : imm_i;
                alu_a_src   = a_pc;
                alu_b_src   = b_four;
                pc_base     = (opcode == op_jal) ? base_pc : base_rs1;
                reg_we      = 1'b1;
                take_target = 1'b1;
            end
            op_branch: begin
                imm_kind = imm_b;
                // eq/ne read zero, the rest read less
                case (funct3)
                    f3_blt, f3_bge:   alu_op = alu_slt;
                    f3_bltu, f3_bgeu: alu_op = alu_sltu;
                    default:          alu_op = alu_sub;
                endcase
                case (funct3)
                    f3_beq:           take_target = zero;
                    f3_bne:           take_target = !zero;
                    f3_blt, f3_bltu:  take_target = less;
                    f3_bge, f3_bgeu:  take_target = !less;
                    default:          take_target = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- hw/core_cfg_pkg.sv
package core_cfg_pkg;

    // datapath word width
    localparam int xlen = 32;

    // architectural integer registers, x0 included
    localparam int reg_count = 32;

    // bits needed to name one register
    localparam int reg_addr_w = 5;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_vector = 32'h0000_0000;

    // wishbone byte lanes for a full word
    localparam int wb_sel_w = xlen / 8;

endpackage

//--- hw/cpu.sv
`timescale 1ns/10ps

module cpu import core_cfg_pkg::*, rv_isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // wishbone classic instruction master
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic [xlen-1:0]       wb_adr,
    output logic [wb_sel_w-1:0]   wb_sel,
    output logic                  wb_we,
    input  logic [xlen-1:0]       wb_dat_i,
    input  logic                  wb_ack,
    // retire port
    output logic                  ret_valid,
    output logic [reg_addr_w-1:0] ret_rd,
    output logic [xlen-1:0]       ret_data,
    output logic                  ret_we,
    output logic [xlen-1:0]       ret_pc,
    output logic [xlen-1:0]       ret_next_pc
);

    logic [xlen-1:0] instr, pc, next_pc, pc_plus4, target, jump_base;
    logic [xlen-1:0] imm, src1, src2, alu_a, alu_b, alu_result;
    logic [reg_addr_w-1:0] rs1, rs2, rd;
    logic exec_en, reg_we, take_target, less, zero;
    imm_kind_t  imm_kind;
    alu_op_t    alu_op;
    alu_a_src_t alu_a_src;
    alu_b_src_t alu_b_src;
    pc_base_t   pc_base;

    // lui reads x0 so the alu add passes the immediate
    assign rs1 = (instr[6:0] == op_lui) ? '0 : instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // read-only word fetches
    assign wb_sel = '1;
    assign wb_we  = 1'b0;

    fetch_fsm i_fetch (.clk, .rst, .wb_ack, .wb_dat_i, .pc, .wb_cyc, .wb_stb, .wb_adr,
                       .instr, .exec_en);

    pc_counter i_pc (.clk, .rst, .load(exec_en), .next_pc, .pc);

    control_unit i_ctrl (.instr, .less, .zero, .imm_kind, .alu_op, .alu_a_src, .alu_b_src,
                         .pc_base, .reg_we, .take_target);

    imm_decoder i_imm (.instr, .imm_kind, .imm);

    // write lands only on the execute edge
    register_file i_rf (.clk, .wen(reg_we && exec_en), .waddr(rd), .wdata(alu_result),
                        .raddr_a(rs1), .raddr_b(rs2), .rdata_a(src1), .rdata_b(src2));

    // operand muxes
    assign alu_a = (alu_a_src == a_pc) ? pc : src1;
    always_comb begin
        case (alu_b_src)
            b_imm:   alu_b = imm;
            b_four:  alu_b = 32'd4;
            default: alu_b = src2;
        endcase
    end

    alu i_alu (.alu_op, .a(alu_a), .b(alu_b), .result(alu_result), .less, .zero);

    // next pc: jump / taken branch target or fall through
    assign pc_plus4  = pc + 32'd4;
    assign jump_base = (pc_base == base_rs1) ? src1 : pc;
    // jalr drops bit 0
    assign target    = (jump_base + imm) & ~{{(xlen-1){1'b0}}, pc_base == base_rs1};
    assign next_pc   = take_target ? target : pc_plus4;

    // retire mirrors the write-back of the execute cycle
    assign ret_valid   = exec_en;
    assign ret_rd      = rd;
    assign ret_data    = alu_result;
    assign ret_we      = reg_we;
    assign ret_pc      = pc;
    assign ret_next_pc = next_pc;

endmodule

//--- hw/fetch_fsm.sv
`timescale 1ns/10ps

module fetch_fsm import core_cfg_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            wb_ack,
    input  logic [xlen-1:0] wb_dat_i,
    input  logic [xlen-1:0] pc,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic [xlen-1:0] wb_adr,
    output logic [xlen-1:0] instr,
    output logic            exec_en
);

    typedef enum logic [1:0] {st_idle, st_fetch, st_exec} state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                // one quiet cycle after reset
                st_idle:  state <= st_fetch;
                // wait as long as the slave needs
                st_fetch: if (wb_ack) state <= st_exec;
                // single execute cycle, then next word
                st_exec:  state <= st_fetch;
                default:  state <= st_idle;
            endcase
        end
    end

    // instruction word latched on the ack edge
    always_ff @(posedge clk) begin
        if (state == st_fetch && wb_ack) begin
            instr <= wb_dat_i;
        end
    end

    // request held for the whole fetch state
    assign wb_cyc  = (state == st_fetch);
    assign wb_stb  = (state == st_fetch);
    // pc stays put until the execute edge
    assign wb_adr  = pc;
    assign exec_en = (state == st_exec);

endmodule

//--- hw/imm_decoder.sv
`timescale 1ns/10ps

module imm_decoder import core_cfg_pkg::*, rv_isa_pkg::*; (
    input  logic [xlen-1:0] instr,
    input  imm_kind_t       imm_kind,
    output logic [xlen-1:0] imm
);

    always_comb begin
        case (imm_kind)
            // 12 bits straight from the top
            imm_i: imm = {{(xlen-12){instr[31]}}, instr[31:20]};
            // split around rd field
            imm_s: imm = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
            // halfword offset, bit 0 implied
            imm_b: imm = {{(xlen-13){instr[31]}}, instr[31], instr[7],
                          instr[30:25], instr[11:8], 1'b0};
            // upper 20, low 12 zero
            imm_u: imm = {instr[31:12], 12'b0};
            // jal offset, scrambled order
            imm_j: imm = {{(xlen-21){instr[31]}}, instr[31], instr[19:12],
                          instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

//--- hw/pc_counter.sv
`timescale 1ns/10ps

module pc_counter import core_cfg_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  logic [xlen-1:0] next_pc,
    output logic [xlen-1:0] pc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_vector;
        end else if (load) begin
            // advances only at the end of execute
            pc <= next_pc;
        end
    end

endmodule

//--- hw/register_file.sv
`timescale 1ns/10ps

module register_file import core_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  wen,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    input  logic [reg_addr_w-1:0] raddr_a,
    input  logic [reg_addr_w-1:0] raddr_b,
    output logic [xlen-1:0]       rdata_a,
    output logic [xlen-1:0]       rdata_b
);

    logic [xlen-1:0] regs [reg_count];

    // x0 never written
    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 reads as zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes, instr[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // alu funct3 values where bit 30 matters
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sr  = 3'b101;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // low three bits follow funct3, bit 3 picks sub / sra
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_kind_t;

    typedef enum logic {a_reg, a_pc} alu_a_src_t;

    typedef enum logic [1:0] {b_reg, b_imm, b_four} alu_b_src_t;

    // jump base, rs1 only for jalr
    typedef enum logic {base_pc, base_rs1} pc_base_t;

endpackage

//--- list.f
hw/core_cfg_pkg.sv
hw/rv_isa_pkg.sv
hw/fetch_fsm.sv
hw/pc_counter.sv
hw/control_unit.sv
hw/imm_decoder.sv
hw/register_file.sv
hw/alu.sv
hw/cpu.sv
tests/retire_monitor.sv
tests/tb_cpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps --top-module tb_cpu -f list.f -o tb_cpu
out=$(./obj_dir/tb_cpu)
echo "$out"
echo "$out" | grep -q "Simulation PASSED"

//--- tests/cpu_vectors.txt
// words 0x00-0x17: program image, one instruction word per token
// word 0x20: record count, then records of: pc rd we data next_pc
@00
ffb00093 4010d113 123451b7 00708013 40018233 0ff1c293
4020d333 0030a3b3 0030b433 00108463 00100693 00109463
0030c463 00100693 0030d463 0030e463 0030f463 00100693
00001497 0080056f 00100693 05d005e7 00100693 00b50633
@20 00000013
00000000 00000001 00000001 fffffffb 00000004
00000004 00000002 00000001 fffffffd 00000008
00000008 00000003 00000001 12345000 0000000c
0000000c 00000000 00000001 00000002 00000010
00000010 00000004 00000001 12345000 00000014
00000014 00000005 00000001 123450ff 00000018
00000018 00000006 00000001 ffffffff 0000001c
0000001c 00000007 00000001 00000001 00000020
00000020 00000008 00000001 00000000 00000024
00000024 00000000 00000000 00000000 0000002c
0000002c 00000000 00000000 00000000 00000030
00000030 00000000 00000000 00000000 00000038
00000038 00000000 00000000 00000000 0000003c
0000003c 00000000 00000000 00000000 00000040
00000040 00000000 00000000 00000000 00000048
00000048 00000009 00000001 00001048 0000004c
0000004c 0000000a 00000001 00000050 00000054
00000054 0000000b 00000001 00000058 0000005c
0000005c 0000000c 00000001 000000a8 00000060

//--- tests/retire_monitor.sv
`timescale 1ns/10ps

module retire_monitor import core_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ret_valid,
    input  logic [reg_addr_w-1:0] ret_rd,
    input  logic [xlen-1:0]       ret_data,
    input  logic                  ret_we,
    input  logic [xlen-1:0]       ret_pc,
    input  logic [xlen-1:0]       ret_next_pc,
    input  logic                  wb_stb,
    input  logic                  wb_cyc,
    input  logic [wb_sel_w-1:0]   wb_sel,
    input  logic                  wb_we,
    input  logic [xlen-1:0]       wb_adr,
    input  logic [31:0]           vectors [256],
    output int                    value_errors,
    output int                    other_errors,
    output logic                  done
);

    // record count word with five-word records after it
    localparam logic [7:0] count_addr   = 8'h20;
    localparam int         retire_limit = 200;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    initial begin : watch
        int              idx;
        int              idle;
        logic [7:0]      base;
        logic            stb_q;
        logic [xlen-1:0] exp_fetch;
        value_errors = 0;
        other_errors = 0;
        done         = 1'b0;
        idx          = 0;
        idle         = 0;
        stb_q        = 1'b0;
        exp_fetch    = reset_vector;
        while (!done) begin
            @(negedge clk);
            if (rst) begin
                // bus and retire port quiet in reset
                compare_value("wb_cyc", 32'd0, 32'(wb_cyc));
                compare_value("wb_stb", 32'd0, 32'(wb_stb));
                compare_value("ret_valid", 32'd0, 32'(ret_valid));
            end else begin
                // full-word read with cyc up alongside stb
                if (wb_stb) begin
                    compare_value("wb_cyc", 32'd1, 32'(wb_cyc));
                    compare_value("wb_sel", 32'({wb_sel_w{1'b1}}), 32'(wb_sel));
                    compare_value("wb_we", 32'd0, 32'(wb_we));
                end
                // each new request targets the previous next pc
                if (wb_stb && !stb_q) begin
                    compare_value("wb_adr", exp_fetch, wb_adr);
                    done = (idx == vectors[count_addr]);
                end
                stb_q = wb_stb;
                if (ret_valid && idx < vectors[count_addr]) begin
                    base = count_addr + 8'd1 + 8'(5 * idx);
                    // no request during the execute cycle
                    compare_value("wb_cyc", 32'd0, 32'(wb_cyc));
                    compare_value("wb_stb", 32'd0, 32'(wb_stb));
                    compare_value("ret_pc", vectors[base], ret_pc);
                    compare_value("ret_we", vectors[base + 8'd2], 32'(ret_we));
                    // rd and data only mean something on a write
                    if (vectors[base + 8'd2][0]) begin
                        compare_value("ret_rd", vectors[base + 8'd1], 32'(ret_rd));
                        compare_value("ret_data", vectors[base + 8'd3], ret_data);
                    end
                    compare_value("ret_next_pc", vectors[base + 8'd4], ret_next_pc);
                    exp_fetch = vectors[base + 8'd4];
                    idx++;
                    idle = 0;
                end else begin
                    idle++;
                    if (idle >= retire_limit) begin
                        $display("no instruction retired within %0d cycles", retire_limit);
                        other_errors++;
                        done = 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- tests/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu import core_cfg_pkg::*; ();

    localparam int              stb_limit  = 200;
    localparam int              done_limit = 20000;
    // byte size of the program image at the start of the vectors file
    localparam logic [xlen-1:0] image_end  = 32'h60;

    logic                  clk, rst, wb_ack;
    logic                  wb_cyc, wb_stb, wb_we;
    logic [xlen-1:0]       wb_adr, wb_dat_i;
    logic [wb_sel_w-1:0]   wb_sel;
    logic                  ret_valid, ret_we;
    logic [reg_addr_w-1:0] ret_rd;
    logic [xlen-1:0]       ret_data, ret_pc, ret_next_pc;
    // program image and expected retire records
    logic [31:0]           vectors [256];
    logic [31:0]           lcg_state;
    int                    value_errors, other_errors;
    logic                  done, stb_lost, timed_out;

    cpu i_dut (.*);

    retire_monitor i_mon (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // wishbone slave with a random ack delay of 0 to 5 cycles
    initial begin : wb_slave
        int waited;
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        stb_lost  = 1'b0;
        lcg_state = 32'h38a5;
        forever begin
            waited = 0;
            @(negedge clk);
            while (!(wb_cyc && wb_stb) && waited < stb_limit) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= stb_limit) begin
                $display("no bus request seen within %0d cycles", stb_limit);
                stb_lost = 1'b1;
            end else begin
                lcg_state = lcg_next(lcg_state);
                repeat ((lcg_state >> 16) % 32'd6) @(negedge clk);
                wb_ack = 1'b1;
                // outside the image the word is a pattern of the full address
                wb_dat_i = (wb_adr < image_end) ? vectors[wb_adr[9:2]]
                                                : wb_adr ^ 32'h5a5a_5a5a;
                @(negedge clk);
                wb_ack = 1'b0;
            end
        end
    end

    initial begin : run_control
        int cycles;
        rst       = 1'b1;
        timed_out = 1'b0;
        $readmemh("tests/cpu_vectors.txt", vectors);
        // reset released on a falling edge after 16 cycles
        repeat (16) @(negedge clk);
        rst    = 1'b0;
        cycles = 0;
        while (!done && !stb_lost && cycles < done_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= done_limit) begin
            $display("program did not finish within %0d cycles", done_limit);
            timed_out = 1'b1;
        end
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors,
                 other_errors + int'(timed_out) + int'(stb_lost));
        if (value_errors + other_errors == 0 && !timed_out && !stb_lost) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
